// File: logic/kcpu_pkg.sv
// shared widths, register ids, opcodes, condition code bits, sequencer states, buffer depth
package kcpu_pkg;

    // plain vector types for the widths that carry a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  cc_t;
    typedef logic [2:0]  psh_idx_t;
    typedef logic [2:0]  credit_t;

    // register targeted by a load strobe
    typedef enum logic [1:0] {
        REG_A,
        REG_B,
        REG_D,
        REG_X
    } reg_id_t;

    typedef enum logic [2:0] {
        S_OPCODE,
        S_OPD_HI,
        S_OPD_LO,
        S_EXEC,
        S_PUSH,
        S_REDIR
    } seq_state_t;

    // buffer size, which is also the credit count the source starts with
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // condition code bit positions, the byte reads E F H I N Z V C from the top
    localparam int CC_N = 3;
    localparam int CC_Z = 2;
    localparam int CC_V = 1;
    localparam int CC_C = 0;

    // supported opcodes
    localparam byte_t OP_NOP      = 8'h12;
    localparam byte_t OP_LDA      = 8'h86;
    localparam byte_t OP_LDB      = 8'hC6;
    localparam byte_t OP_LDD      = 8'hCC;
    localparam byte_t OP_LDX      = 8'h8E;
    localparam byte_t OP_LBRA     = 8'h16;
    localparam byte_t OP_JMP      = 8'h7E;
    localparam byte_t OP_PSHS     = 8'h34;

    // short branches occupy the whole 0x2x row, the low nibble selects the condition
    localparam byte_t OP_BCC_BASE = 8'h20;

endpackage

// File: logic/kcpu_byte_fifo.sv
// four entry instruction byte buffer with credit return and flush on redirect
module kcpu_byte_fifo
    import kcpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  byte_t   in_byte,
    input  logic    pop,
    input  logic    flush,
    output byte_t   head,
    output logic    not_empty,
    output credit_t credit_ret
);

    byte_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  wr_en;
    logic                  rd_en;

    // an arrival during flush is stale, it is dropped but its credit still goes back
    assign wr_en = in_valid && !flush;
    assign rd_en = pop && !flush;

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= '0;
        end else if (flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= credit_t'(count) + credit_t'(in_valid);
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // every pop hands one credit back in the next cycle
            credit_ret <= credit_t'(rd_en);
        end
    end

    // the source only sends while holding a credit, so a full buffer never sees a write
    assert property (@(posedge clk) disable iff (rst) in_valid |-> (count < FIFO_DEPTH));
    assert property (@(posedge clk) disable iff (rst) pop |-> not_empty);

endmodule

// File: logic/kcpu_cond_eval.sv
// branch condition evaluator for the sixteen short branch conditions
module kcpu_cond_eval
    import kcpu_pkg::*;
(
    input  logic [3:0] cond,
    input  cc_t        cc,
    output logic       taken
);

    logic n;
    logic z;
    logic v;
    logic c;

    assign n = cc[CC_N];
    assign z = cc[CC_Z];
    assign v = cc[CC_V];
    assign c = cc[CC_C];

    // odd conditions are the complement of the even one below them
    always_comb begin
        case (cond)
            4'h0: taken = 1'b1;
            4'h1: taken = 1'b0;
            4'h2: taken = !(c || z);
            4'h3: taken = c || z;
            4'h4: taken = !c;
            4'h5: taken = c;
            4'h6: taken = !z;
            4'h7: taken = z;
            4'h8: taken = !v;
            4'h9: taken = v;
            4'hA: taken = !n;
            4'hB: taken = n;
            4'hC: taken = (n == v);
            4'hD: taken = (n != v);
            4'hE: taken = !z && (n == v);
            default: taken = z || (n != v);
        endcase
    end

endmodule

// File: logic/kcpu_psh_count.sv
// push postbyte scanner that walks the set bits from the highest one down
module kcpu_psh_count
    import kcpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  byte_t    postbyte,
    input  logic     step,
    output logic     active,
    output psh_idx_t bit_idx
);

    byte_t mask;

    assign active = (mask != '0);

    // priority encoder, later iterations win so the highest set bit ends up selected
    always_comb begin
        bit_idx = '0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                bit_idx = psh_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mask <= '0;
        end else if (load) begin
            mask <= postbyte;
        end else if (step) begin
            mask[bit_idx] <= 1'b0;
        end
    end

endmodule

// File: logic/kcpu_pc_unit.sv
// program counter with increment per popped byte and relative or absolute load
module kcpu_pc_unit
    import kcpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  inc,
    input  logic  load_rel,
    input  logic  load_abs,
    input  word_t operand,
    output addr_t pc
);

    addr_t pc_nxt;

    // a relative target is taken from the end of the instruction, which pc already holds
    always_comb begin
        if (load_abs) begin
            pc_nxt = operand;
        end else if (load_rel) begin
            pc_nxt = pc + operand;
        end else if (inc) begin
            pc_nxt = pc + 16'd1;
        end else begin
            pc_nxt = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_nxt;
        end
    end

    // the sequencer never pops while it loads a target
    assert property (@(posedge clk) disable iff (rst) $onehot0({inc, load_rel, load_abs}));

endmodule

// File: logic/kcpu_seq.sv
// instruction sequencer FSM with operand assembly, load strobes, push walk and redirects
module kcpu_seq
    import kcpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  byte_t      head,
    input  logic       not_empty,
    input  logic       taken,
    input  logic       psh_active,
    input  psh_idx_t   psh_idx,
    output logic       pop,
    output logic       pc_inc,
    output logic       load_rel,
    output logic       load_abs,
    output word_t      operand,
    output logic [3:0] cond,
    output logic       psh_load,
    output logic       psh_step,
    output logic       flush,
    output logic       reg_we,
    output reg_id_t    reg_sel,
    output word_t      reg_data,
    output logic       psh_we,
    output psh_idx_t   psh_bit,
    output logic       redirect,
    output logic       op_err
);

    seq_state_t state;
    seq_state_t state_nxt;
    byte_t      opcode;
    word_t      opd_q;

    function automatic logic is_bcc(input byte_t op);
        return op[7:4] == OP_BCC_BASE[7:4];
    endfunction

    // number of operand bytes that follow the opcode
    function automatic logic [1:0] opd_len(input byte_t op);
        logic [1:0] len;
        len = 2'd0;
        if (op == OP_LDD || op == OP_LDX || op == OP_LBRA || op == OP_JMP) begin
            len = 2'd2;
        end else if (op == OP_LDA || op == OP_LDB || op == OP_PSHS || is_bcc(op)) begin
            len = 2'd1;
        end
        return len;
    endfunction

    always_comb begin
        state_nxt = state;
        pop       = 1'b0;
        load_rel  = 1'b0;
        load_abs  = 1'b0;
        psh_load  = 1'b0;
        psh_step  = 1'b0;
        reg_we    = 1'b0;
        psh_we    = 1'b0;
        redirect  = 1'b0;
        flush     = 1'b0;
        op_err    = 1'b0;
        case (state)
            S_OPCODE: begin
                if (not_empty) begin
                    pop = 1'b1;
                    case (opd_len(head))
                        2'd2:    state_nxt = S_OPD_HI;
                        2'd1:    state_nxt = S_OPD_LO;
                        default: state_nxt = S_EXEC;
                    endcase
                end
            end
            S_OPD_HI: begin
                if (not_empty) begin
                    pop       = 1'b1;
                    state_nxt = S_OPD_LO;
                end
            end
            S_OPD_LO: begin
                if (not_empty) begin
                    pop = 1'b1;
                    // the postbyte goes straight into the push counter as it is popped
                    if (opcode == OP_PSHS) begin
                        psh_load  = 1'b1;
                        state_nxt = S_PUSH;
                    end else begin
                        state_nxt = S_EXEC;
                    end
                end
            end
            S_EXEC: begin
                state_nxt = S_OPCODE;
                case (opcode)
                    OP_LDA, OP_LDB, OP_LDD, OP_LDX: reg_we = 1'b1;
                    OP_NOP: ;
                    OP_LBRA: begin
                        load_rel  = 1'b1;
                        state_nxt = S_REDIR;
                    end
                    OP_JMP: begin
                        load_abs  = 1'b1;
                        state_nxt = S_REDIR;
                    end
                    default: begin
                        if (!is_bcc(opcode)) begin
                            op_err = 1'b1;
                        end else if (taken) begin
                            load_rel  = 1'b1;
                            state_nxt = S_REDIR;
                        end
                    end
                endcase
            end
            S_PUSH: begin
                if (psh_active) begin
                    psh_we   = 1'b1;
                    psh_step = 1'b1;
                end else begin
                    state_nxt = S_OPCODE;
                end
            end
            S_REDIR: begin
                // pc already holds the target, whatever the buffer holds is from the old stream
                redirect  = 1'b1;
                flush     = 1'b1;
                state_nxt = S_OPCODE;
            end
            default: state_nxt = S_OPCODE;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_LDB:  reg_sel = REG_B;
            OP_LDD:  reg_sel = REG_D;
            OP_LDX:  reg_sel = REG_X;
            default: reg_sel = REG_A;
        endcase
    end

    assign pc_inc   = pop;
    assign operand  = opd_q;
    assign reg_data = opd_q;
    assign cond     = opcode[3:0];
    assign psh_bit  = psh_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_OPCODE;
        end else begin
            state <= state_nxt;
        end
    end

    // short branch offsets are sign extended, 8-bit loads are zero extended
    always_ff @(posedge clk) begin
        if (pop && state == S_OPCODE) begin
            opcode <= head;
            opd_q  <= '0;
        end
        if (pop && state == S_OPD_HI) begin
            opd_q[15:8] <= head;
        end
        if (pop && state == S_OPD_LO) begin
            opd_q[7:0] <= head;
            if (is_bcc(opcode)) begin
                opd_q[15:8] <= {8{head[7]}};
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(reg_we && psh_we));
    assert property (@(posedge clk) disable iff (rst) redirect |=> !redirect);

endmodule

// File: logic/kcpu_ctrl.sv
// control front end top level joining buffer, sequencer, push counter, condition check and pc
module kcpu_ctrl
    import kcpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  byte_t    in_byte,
    input  cc_t      cc,
    output credit_t  credit_ret,
    output addr_t    pc,
    output logic     redirect,
    output addr_t    redirect_addr,
    output logic     reg_we,
    output reg_id_t  reg_sel,
    output word_t    reg_data,
    output logic     psh_we,
    output psh_idx_t psh_bit,
    output logic     op_err
);

    byte_t      head;
    logic       not_empty;
    logic       pop;
    logic       flush;
    logic       taken;
    logic [3:0] cond;
    logic       psh_load;
    logic       psh_step;
    logic       psh_active;
    psh_idx_t   psh_idx;
    logic       pc_inc;
    logic       load_rel;
    logic       load_abs;
    word_t      operand;

    // the source restarts from the pc value shown during the redirect cycle
    assign redirect_addr = pc;

    kcpu_byte_fifo kcpu_byte_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_byte    (in_byte),
        .pop        (pop),
        .flush      (flush),
        .head       (head),
        .not_empty  (not_empty),
        .credit_ret (credit_ret)
    );

    kcpu_seq kcpu_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .head       (head),
        .not_empty  (not_empty),
        .taken      (taken),
        .psh_active (psh_active),
        .psh_idx    (psh_idx),
        .pop        (pop),
        .pc_inc     (pc_inc),
        .load_rel   (load_rel),
        .load_abs   (load_abs),
        .operand    (operand),
        .cond       (cond),
        .psh_load   (psh_load),
        .psh_step   (psh_step),
        .flush      (flush),
        .reg_we     (reg_we),
        .reg_sel    (reg_sel),
        .reg_data   (reg_data),
        .psh_we     (psh_we),
        .psh_bit    (psh_bit),
        .redirect   (redirect),
        .op_err     (op_err)
    );

    // the postbyte is captured straight from the buffer head as it is popped
    kcpu_psh_count kcpu_psh_count_inst (
        .clk      (clk),
        .rst      (rst),
        .load     (psh_load),
        .postbyte (head),
        .step     (psh_step),
        .active   (psh_active),
        .bit_idx  (psh_idx)
    );

    kcpu_cond_eval kcpu_cond_eval_inst (
        .cond  (cond),
        .cc    (cc),
        .taken (taken)
    );

    kcpu_pc_unit kcpu_pc_unit_inst (
        .clk      (clk),
        .rst      (rst),
        .inc      (pc_inc),
        .load_rel (load_rel),
        .load_abs (load_abs),
        .operand  (operand),
        .pc       (pc)
    );

endmodule

// File: sim/kcpu_clock_gen.sv
// testbench clock source and synchronous reset generator with a restart request
module kcpu_clock_gen (
    input  logic rst_req,
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_NS      = 5;
    localparam int RESET_CYCLES = 5;

    // reset is held from time zero and again for a full count after every request
    int rst_cnt = RESET_CYCLES;

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

    always @(posedge clk) begin
        if (rst_req) begin
            rst_cnt <= RESET_CYCLES;
        end else if (rst_cnt != 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign rst = (rst_cnt != 0);

endmodule

// File: sim/kcpu_ctrl_tb.sv
// testbench for the control front end with byte source model, case reader, compare tasks, watchdog
module kcpu_ctrl_tb
    import kcpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_NS    = 10;
    localparam int CASE_CYCLES = 200;
    localparam int IDLE_CYCLES = 16;
    localparam int KIND_PSH    = 4;
    localparam int KIND_REDIR  = 5;
    localparam int KIND_ILL    = 6;

    logic     clk;
    logic     rst;
    logic     rst_req;
    logic     in_valid;
    byte_t    in_byte;
    cc_t      cc;
    credit_t  credit_ret;
    addr_t    pc;
    logic     redirect;
    addr_t    redirect_addr;
    logic     reg_we;
    reg_id_t  reg_sel;
    word_t    reg_data;
    logic     psh_we;
    psh_idx_t psh_bit;
    logic     op_err;

    logic [15:0] cases_mem [0:511];
    int          rd_idx;
    int          case_count;
    int          mismatch_count;
    int          other_count;
    int          credits;
    int          seed = 29427;
    byte_t       image [addr_t];
    int          exp_kind [$];
    word_t       exp_val [$];

    kcpu_clock_gen kcpu_clock_gen_inst (
        .rst_req (rst_req),
        .clk     (clk),
        .rst     (rst)
    );

    kcpu_ctrl kcpu_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_byte       (in_byte),
        .cc            (cc),
        .credit_ret    (credit_ret),
        .pc            (pc),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .reg_we        (reg_we),
        .reg_sel       (reg_sel),
        .reg_data      (reg_data),
        .psh_we        (psh_we),
        .psh_bit       (psh_bit),
        .op_err        (op_err)
    );

    function automatic logic [15:0] next_word();
        logic [15:0] w;
        w = cases_mem[rd_idx];
        rd_idx++;
        return w;
    endfunction

    // unlisted addresses read as an illegal 0x0x opcode folded from the whole address
    // so a stray pop shows up as an event
    function automatic byte_t fetch_byte(input addr_t a);
        if (image.exists(a)) begin
            return image[a];
        end
        return {4'h0, a[15:12] ^ a[11:8] ^ a[7:4] ^ a[3:0]};
    endfunction

    task automatic check_reg(input reg_id_t got_id, input word_t got_val,
                             input reg_id_t exp_id, input word_t exp_v);
        if (got_id !== exp_id || got_val !== exp_v) begin
            mismatch_count++;
            $display("mismatch at %0t ns: load reg %0d = %h, expected reg %0d = %h",
                     $time, got_id, got_val, exp_id, exp_v);
        end
    endtask

    task automatic check_psh(input psh_idx_t got, input psh_idx_t exp_bit);
        if (got !== exp_bit) begin
            mismatch_count++;
            $display("mismatch at %0t ns: push bit %0d, expected %0d", $time, got, exp_bit);
        end
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp_addr, input string what);
        if (got !== exp_addr) begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp_addr);
        end
    endtask

    task automatic check_credit(input credit_t got, input credit_t exp_cnt);
        if (got !== exp_cnt) begin
            mismatch_count++;
            $display("mismatch at %0t ns: source holds %0d credits when idle, expected %0d",
                     $time, got, exp_cnt);
        end
    endtask

    // takes the oldest expected event, and flags it when it is of another kind
    task automatic take_event(input string what, input int lo, input int hi,
                              output int kind, output word_t val, output bit ok);
        ok = 1'b0;
        if (exp_kind.size() == 0) begin
            other_count++;
            $display("unexpected %s event at %0t ns", what, $time);
        end else begin
            kind = exp_kind.pop_front();
            val  = exp_val.pop_front();
            if (kind < lo || kind > hi) begin
                other_count++;
                $display("a %s event came at %0t ns where event kind %0d was due",
                         what, $time, kind);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic watch_events();
        int    kind;
        word_t val;
        bit    ok;
        if (reg_we) begin
            take_event("load", 0, 3, kind, val, ok);
            if (ok) check_reg(reg_sel, reg_data, reg_id_t'(kind), val);
        end
        if (psh_we) begin
            take_event("push", KIND_PSH, KIND_PSH, kind, val, ok);
            if (ok) check_psh(psh_bit, psh_idx_t'(val));
        end
        if (op_err) begin
            take_event("illegal opcode", KIND_ILL, KIND_ILL, kind, val, ok);
            if (ok) check_pc(pc, addr_t'(val), "pc after illegal opcode");
        end
        if (redirect) begin
            take_event("redirect", KIND_REDIR, KIND_REDIR, kind, val, ok);
            if (ok) check_pc(redirect_addr, addr_t'(val), "redirect target");
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst_req = 1'b1;
        @(posedge clk);
        #1;
        rst_req = 1'b0;
        do @(negedge clk); while (rst);
    endtask

    task automatic run_case(input int idx);
        int    nseg;
        int    nbytes;
        int    nev;
        int    idle;
        addr_t seg_addr;
        addr_t end_addr;
        addr_t final_pc;
        addr_t fetch_addr;
        addr_t redir_target;
        bit    redir_pend;
        image.delete();
        exp_kind.delete();
        exp_val.delete();
        cc       = cc_t'(next_word());
        nseg     = next_word();
        end_addr = next_word();
        final_pc = next_word();
        for (int s = 0; s < nseg; s++) begin
            seg_addr = next_word();
            nbytes   = next_word();
            for (int b = 0; b < nbytes; b++) begin
                image[seg_addr + addr_t'(b)] = byte_t'(next_word());
            end
        end
        nev = next_word();
        for (int e = 0; e < nev; e++) begin
            exp_kind.push_back(int'(next_word()));
            exp_val.push_back(next_word());
        end
        reset_dut();
        credits    = FIFO_DEPTH;
        fetch_addr = '0;
        redir_pend = 1'b0;
        idle       = 0;
        while (idle < IDLE_CYCLES) begin
            @(posedge clk);
            #1;
            if (redir_pend) begin
                fetch_addr = redir_target;
                redir_pend = 1'b0;
            end
            if (credits > 0 && fetch_addr != end_addr && ($random(seed) & 3) != 0) begin
                in_valid   = 1'b1;
                in_byte    = fetch_byte(fetch_addr);
                fetch_addr = fetch_addr + 16'd1;
                credits--;
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
            credits += credit_ret;
            if (credits < 0 || credits > FIFO_DEPTH) begin
                other_count++;
                $display("source credit count went to %0d at %0t ns in case %0d",
                         credits, $time, idx);
            end
            watch_events();
            if (redirect) begin
                redir_pend   = 1'b1;
                redir_target = redirect_addr;
            end
            if (fetch_addr == end_addr && credit_ret == '0 && !redirect && !in_valid) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        if (exp_kind.size() != 0) begin
            other_count++;
            $display("case %0d ended with %0d expected events missing", idx, exp_kind.size());
        end
        check_pc(pc, final_pc, "final pc");
        check_credit(credit_t'(credits), credit_t'(FIFO_DEPTH));
    endtask

    initial begin
        rst_req        = 1'b0;
        in_valid       = 1'b0;
        in_byte        = '0;
        cc             = '0;
        mismatch_count = 0;
        other_count    = 0;
        rd_idx         = 0;
        $readmemh("sim/kcpu_cases.txt", cases_mem);
        case_count = next_word();
        if (case_count == 0) begin
            other_count++;
            $display("no test cases were read from the case file");
        end
        for (int c = 0; c < case_count; c++) begin
            run_case(c);
        end
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // the run may take at most a fixed number of cycles for every case
    initial begin
        wait (case_count != 0);
        #(case_count * CASE_CYCLES * CYCLE_NS);
        $display("timeout, the cases did not finish in time");
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: sim/kcpu_cases.txt
// case count, then per case a header of cc, segment count, end address and final pc,
// segments of address, byte count and bytes, and an event count with kind and value pairs
// event kinds are 0 to 3 for a load of A B D X, 4 push bit, 5 redirect target, 6 illegal at pc
0008
// immediate loads of all four registers and a trailing NOP
00 0001 000B 000B
0000 000B 86 5A C6 A5 CC 12 34 8E BE EF 12
0004 0 005A 1 00A5 2 1234 3 BEEF
// all sixteen branch conditions with N and C set
09 0002 0020 0020
0000 0010 20 00 21 00 22 00 23 00 24 00 25 00 26 00 27 00
0010 0010 28 00 29 00 2A 00 2B 00 2C 00 2D 00 2E 00 2F 00
0008 5 0002 5 0008 5 000C 5 000E 5 0012 5 0018 5 001C 5 0020
// all sixteen branch conditions with Z and V set
06 0002 0020 0020
0000 0010 20 00 21 00 22 00 23 00 24 00 25 00 26 00 27 00
0010 0010 28 00 29 00 2A 00 2B 00 2C 00 2D 00 2E 00 2F 00
0008 5 0002 5 0008 5 000A 5 0010 5 0014 5 0016 5 001C 5 0020
// forward and backward short branches, then a jump
00 0004 0031 0031
0000 0002 20 10
0006 0005 86 33 7E 00 30
0012 0004 C6 22 20 F0
0030 0001 12
0005 5 0012 1 0022 5 0006 0 0033 5 0030
// long branch forward and back, a jump far away, a load there
00 0004 1236 1236
0000 0005 16 00 20 86 99
0023 0003 16 FF E0
0006 0003 7E 12 34
1234 0002 86 77
0004 5 0023 5 0006 5 1234 0 0077
// push of a sparse, an empty and a full postbyte
00 0001 0007 0007
0000 0007 34 A5 34 00 34 FF 12
000C 4 7 4 5 4 2 4 0 4 7 4 6 4 5 4 4 4 3 4 2 4 1 4 0
// illegal opcodes between loads
00 0001 0006 0006
0000 0006 01 86 42 FF C6 24
0004 6 0001 0 0042 6 0004 1 0024
// jumps taken while the buffer is full
00 0003 0022 0022
0000 0003 7E 00 10
0010 0005 12 12 7E 00 20
0020 0002 86 01
0003 5 0010 5 0020 0 0001

// File: list.f
logic/kcpu_pkg.sv
logic/kcpu_byte_fifo.sv
logic/kcpu_cond_eval.sv
logic/kcpu_psh_count.sv
logic/kcpu_pc_unit.sv
logic/kcpu_seq.sv
logic/kcpu_ctrl.sv
sim/kcpu_clock_gen.sv
sim/kcpu_ctrl_tb.sv
